/* clear_prng.f */
+incdir+verilog
+incdir+tests
verilog/clear_prng_pkg.sv
verilog/entropy_packer.sv
verilog/clear_lfsr.sv
verilog/clear_share_out.sv
verilog/clear_prng.sv
tests/tb_clear_prng.sv

/* tests/clear_prng_model.svh */
/*
 * Reference model for the clearing PRNG testbench.
 * Included inside the testbench module, needs the config macros first.
 */
`ifndef CLEAR_PRNG_MODEL_SVH
`define CLEAR_PRNG_MODEL_SVH

// One Galois step, taps folded in when bit 0 leaves the register
function automatic logic [`CLR_WIDTH-1:0] lfsr_advance(input logic [`CLR_WIDTH-1:0] s);
  logic [`CLR_WIDTH-1:0] shifted;
  shifted = s >> 1;
  if (s[0]) begin
    shifted = shifted ^ `CLR_LFSR_TAPS;
  end
  return shifted;
endfunction

// Odd-multiplier rule, bit i takes source bit (i * mul + add) mod width
function automatic logic [`CLR_WIDTH-1:0] permute_bits(input logic [`CLR_WIDTH-1:0] src,
                                                       input int mul, input int add);
  logic [`CLR_WIDTH-1:0] res;
  int i;
  for (i = 0; i < `CLR_WIDTH; i++) begin
    res[i] = src[(i * mul + add) % `CLR_WIDTH];
  end
  return res;
endfunction

// PRINCE S-box, written out entry by entry
function automatic logic [3:0] sbox_nibble(input logic [3:0] x);
  case (x)
    4'h0: return 4'hB;
    4'h1: return 4'hF;
    4'h2: return 4'h3;
    4'h3: return 4'h2;
    4'h4: return 4'hA;
    4'h5: return 4'hC;
    4'h6: return 4'h9;
    4'h7: return 4'h1;
    4'h8: return 4'h6;
    4'h9: return 4'h7;
    4'hA: return 4'h8;
    4'hB: return 4'h0;
    4'hC: return 4'hE;
    4'hD: return 4'h5;
    4'hE: return 4'hD;
    default: return 4'h4;
  endcase
endfunction

// Expected share 0 for a given register state
function automatic logic [`CLR_WIDTH-1:0] nonlinear_out(input logic [`CLR_WIDTH-1:0] s);
  logic [`CLR_WIDTH-1:0] p;
  logic [`CLR_WIDTH-1:0] res;
  int n;
  p = permute_bits(s, `CLR_STATE_PERM_MUL, `CLR_STATE_PERM_ADD);
  for (n = 0; n < `CLR_WIDTH / 4; n++) begin
    res[4*n +: 4] = sbox_nibble(p[4*n +: 4]);
  end
  return res;
endfunction

// Stimulus LCG, numerical recipes constants
function automatic logic [31:0] lcg_next(input logic [31:0] s);
  return s * 32'd1664525 + 32'd1013904223;
endfunction

`endif

/* tests/tb_clear_prng.sv */
/*
 * Testbench for the clearing PRNG top level.
 * Applies a table of idle, data and reseed steps and checks against the model.
 */
`include "clear_prng_config.svh"

module tb_clear_prng;

  `include "clear_prng_model.svh"

  localparam int NUM_STEPS = 10;
  localparam int OP_IDLE = 0;
  localparam int OP_DATA = 1;
  localparam int OP_RESEED = 2;
  localparam int OP_BOTH = 3;

  logic                          clk_i;
  logic                          rst_ni;
  logic                          data_req_i;
  logic                          data_ack_o;
  logic [`CLR_WIDTH-1:0]         data_share0_o;
  logic [`CLR_WIDTH-1:0]         data_share1_o;
  logic                          reseed_req_i;
  logic                          reseed_ack_o;
  logic                          entropy_req_o;
  logic                          entropy_ack_i;
  logic [`CLR_ENTROPY_WIDTH-1:0] entropy_i;

  // Step table, one row per test
  int                            step_op    [NUM_STEPS];
  int                            step_count [NUM_STEPS];
  int                            step_gap   [NUM_STEPS];
  logic [`CLR_ENTROPY_WIDTH-1:0] step_w0    [NUM_STEPS];
  logic [`CLR_ENTROPY_WIDTH-1:0] step_w1    [NUM_STEPS];
  logic                          table_ready = 1'b0;

  // Model register state and bookkeeping
  logic [`CLR_WIDTH-1:0] mstate;
  logic [31:0]           lcg_state = 32'h02b10886;
  int                    errors = 0;
  int                    checks = 0;

  clear_prng dut0 (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .data_req_i    (data_req_i),
    .data_ack_o    (data_ack_o),
    .data_share0_o (data_share0_o),
    .data_share1_o (data_share1_o),
    .reseed_req_i  (reseed_req_i),
    .reseed_ack_o  (reseed_ack_o),
    .entropy_req_o (entropy_req_o),
    .entropy_ack_i (entropy_ack_i),
    .entropy_i     (entropy_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic add_step(input int i, input int op, input int count,
                          input logic [31:0] w0, input logic [31:0] w1, input int gap);
    step_op[i] = op;
    step_count[i] = count;
    step_w0[i] = w0;
    step_w1[i] = w1;
    step_gap[i] = gap;
  endtask

  task automatic fill_table();
    //       idx  op         cycles  word 0         word 1         max gap
    add_step(0, OP_IDLE,   3,  32'h0,         32'h0,         0);
    add_step(1, OP_DATA,   12, 32'h0,         32'h0,         0);
    add_step(2, OP_RESEED, 0,  32'h1234_5678, 32'h9ABC_DEF0, 3);
    add_step(3, OP_DATA,   8,  32'h0,         32'h0,         0);
    add_step(4, OP_BOTH,   0,  32'h0BAD_F00D, 32'h7E57_C0DE, 4);
    add_step(5, OP_DATA,   6,  32'h0,         32'h0,         0);
    add_step(6, OP_RESEED, 0,  32'h0,         32'h0,         2);
    add_step(7, OP_DATA,   5,  32'h0,         32'h0,         0);
    add_step(8, OP_BOTH,   0,  32'hFFFF_0000, 32'h0000_0001, 0);
    add_step(9, OP_IDLE,   2,  32'h0,         32'h0,         0);
    table_ready = 1'b1;
  endtask

  // Worst-case cycles of one step, gaps at their maximum
  function automatic int step_cycles(input int i);
    if (step_op[i] == OP_RESEED || step_op[i] == OP_BOTH) begin
      return 2 * (step_gap[i] + 1) + 1;
    end
    return step_count[i];
  endfunction

  function automatic string op_name(input int op);
    case (op)
      OP_IDLE: return "idle";
      OP_DATA: return "data";
      OP_RESEED: return "reseed";
      default: return "reseed with data";
    endcase
  endfunction

  task automatic check_value(input string name, input logic [`CLR_WIDTH-1:0] actual,
                             input logic [`CLR_WIDTH-1:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED at %0t: %s actual %h expected %h", $time, name, actual, expected);
    end
  endtask

  // Both shares from the model state
  task automatic check_shares();
    logic [`CLR_WIDTH-1:0] exp_share0;
    exp_share0 = nonlinear_out(mstate);
    check_value("data_share0_o", data_share0_o, exp_share0);
    check_value("data_share1_o", data_share1_o,
                permute_bits(exp_share0, `CLR_SHARE_PERM_MUL, `CLR_SHARE_PERM_ADD));
  endtask

  task automatic run_idle(input int count);
    int c;
    for (c = 0; c < count; c++) begin
      @(posedge clk_i);
      data_req_i <= 1'b0;
      reseed_req_i <= 1'b0;
      entropy_ack_i <= 1'b0;
      @(negedge clk_i);
      check_value("data_ack_o", data_ack_o, 0);
      check_value("entropy_req_o", entropy_req_o, 0);
      check_value("reseed_ack_o", reseed_ack_o, 0);
      check_shares();
    end
  endtask

  // Mostly requests, with LCG-chosen idle cycles in between
  task automatic run_data(input int count);
    int   c;
    logic req;
    for (c = 0; c < count; c++) begin
      lcg_state = lcg_next(lcg_state);
      req = (lcg_state[23:22] != 2'b00);
      @(posedge clk_i);
      data_req_i <= req;
      reseed_req_i <= 1'b0;
      @(negedge clk_i);
      check_value("data_ack_o", data_ack_o, req);
      check_value("entropy_req_o", entropy_req_o, 0);
      check_value("reseed_ack_o", reseed_ack_o, 0);
      check_shares();
      // Handshake steps the register at the coming edge
      if (req) begin
        mstate = lfsr_advance(mstate);
      end
    end
  endtask

  task automatic run_reseed(input logic [31:0] w0, input logic [31:0] w1,
                            input int max_gap, input logic with_data);
    int          w;
    int          c;
    int          gap;
    logic        ack;
    logic [31:0] word;
    for (w = 0; w < 2; w++) begin
      lcg_state = lcg_next(lcg_state);
      gap = (lcg_state >> 16) % (max_gap + 1);
      word = (w == 0) ? w0 : w1;
      for (c = 0; c <= gap; c++) begin
        ack = (c == gap);
        @(posedge clk_i);
        reseed_req_i <= 1'b1;
        data_req_i <= with_data;
        entropy_ack_i <= ack;
        // Junk on the bus during gaps must not be taken
        entropy_i <= ack ? word : ~word;
        @(negedge clk_i);
        check_value("entropy_req_o", entropy_req_o, 1);
        check_value("data_ack_o", data_ack_o, 0);
        check_value("reseed_ack_o", reseed_ack_o, ack && (w == 1));
        check_shares();
      end
    end
    // Seed is loaded at this edge, zero falls back to the default
    mstate = ({w1, w0} == '0) ? `CLR_DEFAULT_SEED : {w1, w0};
    @(posedge clk_i);
    reseed_req_i <= 1'b0;
    data_req_i <= 1'b0;
    entropy_ack_i <= 1'b0;
    @(negedge clk_i);
    check_value("reseed_ack_o", reseed_ack_o, 0);
    check_value("entropy_req_o", entropy_req_o, 0);
    check_shares();
  endtask

  // Watchdog sized from the table
  initial begin
    int total;
    int i;
    wait (table_ready);
    total = 4;
    for (i = 0; i < NUM_STEPS; i++) begin
      total += step_cycles(i);
    end
    #(total * 8 + 200);
    $display("Timeout: the run did not finish within %0d cycles", total);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    int i;
    int errors_before;
    rst_ni = 1'b0;
    data_req_i = 1'b0;
    reseed_req_i = 1'b0;
    entropy_ack_i = 1'b0;
    entropy_i = '0;
    mstate = `CLR_DEFAULT_SEED;
    fill_table();
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (i = 0; i < NUM_STEPS; i++) begin
      errors_before = errors;
      case (step_op[i])
        OP_IDLE: run_idle(step_count[i]);
        OP_DATA: run_data(step_count[i]);
        OP_RESEED: run_reseed(step_w0[i], step_w1[i], step_gap[i], 1'b0);
        default: run_reseed(step_w0[i], step_w1[i], step_gap[i], 1'b1);
      endcase
      $display("Step %0d %s: %s", i, op_name(step_op[i]),
               (errors == errors_before) ? "ok" : "mismatches");
    end
    $display("Steps %0d, checks %0d, errors %0d", NUM_STEPS, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* verilog/clear_lfsr.sv */
/*
 * Processing part of the clearing PRNG.
 * 64-bit Galois LFSR with seed load, followed by a fixed bit permutation
 * and a nibble-wise PRINCE S-box layer on the output.
 */
`include "clear_prng_config.svh"

module clear_lfsr import clear_prng_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,

  // Step request, one shift per cycle
  input  logic       lfsr_en_i,

  // Seed load, wins over a step
  input  logic       seed_en_i,
  input  clr_state_t seed_i,

  // Non-linear output
  output clr_state_t state_o
);

  clr_state_t lfsr_q;
  clr_state_t lfsr_d;
  clr_state_t lfsr_step;
  clr_state_t seed_fixed;
  clr_state_t state_perm;
  clr_state_t state_nl;

  // Galois step
  // shift right, fold taps in when the outgoing bit is set
  assign lfsr_step = lfsr_q[0] ? ((lfsr_q >> 1) ^ `CLR_LFSR_TAPS) : (lfsr_q >> 1);

  // All-zero would lock the register, use the default seed instead
  assign seed_fixed = (seed_i == '0) ? `CLR_DEFAULT_SEED : seed_i;

  // Next state select
  always_comb begin
    lfsr_d = lfsr_q;
    if (seed_en_i) begin
      lfsr_d = seed_fixed;
    end else if (lfsr_en_i) begin
      lfsr_d = lfsr_step;
    end
  end

  // State register, comes out of reset at the default seed
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= `CLR_DEFAULT_SEED;
    end else begin
      lfsr_q <= lfsr_d;
    end
  end

  // State permutation
  // bit i takes state bit (i * MUL + ADD) mod width
  for (genvar i = 0; i < `CLR_WIDTH; i++) begin : gen_state_perm
    localparam int unsigned SrcIdx =
        (i * `CLR_STATE_PERM_MUL + `CLR_STATE_PERM_ADD) % `CLR_WIDTH;
    assign state_perm[i] = lfsr_q[SrcIdx];
  end

  // Non-linear layer
  // every nibble goes through the PRINCE S-box on its own
  for (genvar n = 0; n < `CLR_WIDTH / 4; n++) begin : gen_sbox
    assign state_nl[4*n +: 4] = PRINCE_SBOX[state_perm[4*n +: 4]];
  end

  assign state_o = state_nl;

endmodule

/* verilog/clear_prng.sv */
/*
 * Top level of the pseudo-random generator for register wiping.
 * Ties the entropy packer, the LFSR core and the share output together.
 */
module clear_prng import clear_prng_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_ni,

  // Data side, consumer of clearing values
  input  logic          data_req_i,
  output logic          data_ack_o,
  output clr_state_t    data_share0_o,
  output clr_state_t    data_share1_o,

  // Reseed side, consumer
  input  logic          reseed_req_i,
  output logic          reseed_ack_o,

  // Reseed side, entropy source
  output logic          entropy_req_o,
  input  logic          entropy_ack_i,
  input  entropy_word_t entropy_i
);

  logic       seed_valid;
  clr_state_t seed;
  logic       lfsr_en;
  clr_state_t lfsr_state;

  // Two entropy words into one seed
  entropy_packer u_packer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .reseed_req_i  (reseed_req_i),
    .entropy_req_o (entropy_req_o),
    .entropy_ack_i (entropy_ack_i),
    .entropy_i     (entropy_i),
    .seed_valid_o  (seed_valid),
    .seed_o        (seed)
  );

  // Reseed finishes with the seed load
  assign reseed_ack_o = seed_valid;

  // State register and non-linear output
  clear_lfsr u_lfsr (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .lfsr_en_i (lfsr_en),
    .seed_en_i (seed_valid),
    .seed_i    (seed),
    .state_o   (lfsr_state)
  );

  // Arbitration and shares
  clear_share_out u_out (
    .data_req_i    (data_req_i),
    .reseed_req_i  (reseed_req_i),
    .data_ack_o    (data_ack_o),
    .lfsr_en_o     (lfsr_en),
    .state_i       (lfsr_state),
    .data_share0_o (data_share0_o),
    .data_share1_o (data_share1_o)
  );

endmodule

/* verilog/clear_prng_config.svh */
/*
 * Build-time constants for the clearing PRNG.
 * Include wherever a width, seed, tap mask or permutation rule is needed.
 */
`ifndef CLEAR_PRNG_CONFIG_SVH
`define CLEAR_PRNG_CONFIG_SVH

// LFSR state and share width
`define CLR_WIDTH 64
// One entropy word, half of a seed
`define CLR_ENTROPY_WIDTH 32

// Reset state, also replaces an all-zero seed
`define CLR_DEFAULT_SEED 64'h5A3C_96E1_0F87_B24D
// Galois feedback mask for a maximal-length 64-bit polynomial
`define CLR_LFSR_TAPS 64'hD800_0000_0000_0000

// Output bit i takes source bit (i * MUL + ADD) mod 64, MUL odd keeps it bijective
`define CLR_STATE_PERM_MUL 13
`define CLR_STATE_PERM_ADD 7
`define CLR_SHARE_PERM_MUL 29
`define CLR_SHARE_PERM_ADD 3

`endif

/* verilog/clear_prng_pkg.sv */
/*
 * Shared types and the S-box constant of the clearing PRNG.
 * Modules import it with a wildcard in their header.
 */
`include "clear_prng_config.svh"

package clear_prng_pkg;

  // LFSR state, also the type of each share
  typedef logic [`CLR_WIDTH-1:0] clr_state_t;

  // One word from the entropy source
  typedef logic [`CLR_ENTROPY_WIDTH-1:0] entropy_word_t;

  // Sixteen 4-bit entries, index 0 in the lowest nibble
  typedef logic [15:0][3:0] prince_sbox_t;

  // PRINCE S-box
  // 0..15 -> B F 3 2 A C 9 1 6 7 8 0 E 5 D 4
  parameter prince_sbox_t PRINCE_SBOX = 64'h4D5E_0876_19CA_23FB;

endpackage

/* verilog/clear_share_out.sv */
/*
 * Output side of the clearing PRNG.
 * Arbitrates data against reseed requests, drives the LFSR step enable
 * and forms both masking shares from the non-linear state.
 */
`include "clear_prng_config.svh"

module clear_share_out import clear_prng_pkg::*; (
  // Consumer requests
  input  logic       data_req_i,
  input  logic       reseed_req_i,
  output logic       data_ack_o,

  // Step enable towards the LFSR
  output logic       lfsr_en_o,

  // Non-linear LFSR output
  input  clr_state_t state_i,

  // Clearing shares
  output clr_state_t data_share0_o,
  output clr_state_t data_share1_o
);

  // Reseeding always wins, data waits while it is pending
  assign data_ack_o = reseed_req_i ? 1'b0 : data_req_i;

  // Advance only on a completed data handshake
  assign lfsr_en_o = data_req_i & data_ack_o;

  // Share 0 is the state itself
  assign data_share0_o = state_i;

  // Share 1 uses its own permutation of share 0
  for (genvar i = 0; i < `CLR_WIDTH; i++) begin : gen_share_perm
    localparam int unsigned SrcIdx =
        (i * `CLR_SHARE_PERM_MUL + `CLR_SHARE_PERM_ADD) % `CLR_WIDTH;
    assign data_share1_o[i] = state_i[SrcIdx];
  end

endmodule

/* verilog/entropy_packer.sv */
/*
 * Input side of the clearing PRNG.
 * Requests entropy while a reseed is pending, buffers the first word and
 * presents the packed 64-bit seed for one cycle with the second word.
 */
module entropy_packer import clear_prng_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_ni,

  // Reseed request from the consumer
  input  logic          reseed_req_i,

  // Entropy source handshake
  output logic          entropy_req_o,
  input  logic          entropy_ack_i,
  input  entropy_word_t entropy_i,

  // Packed seed towards the LFSR
  output logic          seed_valid_o,
  output clr_state_t    seed_o
);

  entropy_word_t buffer_q;
  logic          buffer_valid_q;
  logic          xfer;

  // Only ask for entropy while the consumer wants a reseed
  // A stalled source just keeps the request up
  assign entropy_req_o = reseed_req_i;

  // One word moves on each cycle with request and ack
  assign xfer = entropy_req_o & entropy_ack_i;

  // Flag marks a held first word
  // toggles on every transfer, so it clears with the second one
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      buffer_valid_q <= 1'b0;
    end else if (xfer) begin
      buffer_valid_q <= ~buffer_valid_q;
    end
  end

  // First word capture
  always_ff @(posedge clk_i) begin
    if (xfer && !buffer_valid_q) begin
      buffer_q <= entropy_i;
    end
  end

  // Seed completes in the cycle of the second transfer
  assign seed_valid_o = xfer & buffer_valid_q;

  // Second word on top, buffered first word below
  assign seed_o = {entropy_i, buffer_q};

endmodule
